//--- Bender.yml
package:
  name: aes_unit

sources:
  - hw/AesPkg.sv
  - hw/RoundKeyBus.sv
  - hw/KeyExpander.sv
  - hw/RoundKeyStore.sv
  - hw/EncryptCore.sv
  - hw/DecryptCore.sv
  - hw/AesUnit.sv
  - target: test
    files:
      - tests/AesChecker.sv
      - tests/AesUnitTb.sv

//--- hw/AesPkg.sv
// AES-128 shared definitions
// State and key types, the round count, and the byte-level transforms both cores use

package AesPkg;

  typedef logic [7:0]   byte_t;
  typedef logic [31:0]  word_t;
  // Byte 0 sits in the top bits, bytes run down each column in turn
  typedef logic [127:0] state_t;
  typedef logic [127:0] roundKey_t;
  typedef logic [3:0]   roundIdx_t;

  localparam roundIdx_t NumRounds = 4'd10;

  function automatic byte_t getByte(state_t s, int i);
    return s[127 - 8*i -: 8];
  endfunction

  // Multiply by x in GF(2^8), reduction polynomial 0x11b
  function automatic byte_t xtime(byte_t a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic byte_t gmul(byte_t a, byte_t b);
    byte_t r;
    byte_t p;
    r = '0;
    p = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
        r = r ^ p;
      p = xtime(p);
    end
    return r;
  endfunction

  // Inverse as a^254, zero maps to zero
  function automatic byte_t gfInv(byte_t a);
    byte_t r;
    byte_t p;
    r = 8'h01;
    p = a;
    for (int i = 1; i < 8; i++)
    begin
      p = gmul(p, p);
      r = gmul(r, p);
    end
    return r;
  endfunction

  function automatic byte_t rotl8(byte_t b, int n);
    return byte_t'(b << n) | byte_t'(b >> (8 - n));
  endfunction

  // Forward S-box: field inverse, then the affine map
  function automatic byte_t sbox(byte_t b);
    byte_t v;
    v = gfInv(b);
    return v ^ rotl8(v, 1) ^ rotl8(v, 2) ^ rotl8(v, 3) ^ rotl8(v, 4) ^ 8'h63;
  endfunction

  // Inverse affine map first, then the field inverse
  function automatic byte_t invSbox(byte_t b);
    return gfInv(rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05);
  endfunction

  function automatic state_t subBytes(state_t s);
    state_t r;
    for (int i = 0; i < 16; i++)
      r[127 - 8*i -: 8] = sbox(getByte(s, i));
    return r;
  endfunction

  function automatic state_t invSubBytes(state_t s);
    state_t r;
    for (int i = 0; i < 16; i++)
      r[127 - 8*i -: 8] = invSbox(getByte(s, i));
    return r;
  endfunction

  // Row r rotates left by r columns
  function automatic state_t shiftRows(state_t s);
    state_t r;
    for (int c = 0; c < 4; c++)
      for (int row = 0; row < 4; row++)
        r[127 - 8*(4*c + row) -: 8] = getByte(s, 4*((c + row) % 4) + row);
    return r;
  endfunction

  function automatic state_t invShiftRows(state_t s);
    state_t r;
    for (int c = 0; c < 4; c++)
      for (int row = 0; row < 4; row++)
        r[127 - 8*(4*c + row) -: 8] = getByte(s, 4*((c - row + 4) % 4) + row);
    return r;
  endfunction

  // Circulant column mix, k0..k3 is the first matrix row
  function automatic state_t mixState(state_t s, byte_t k0, byte_t k1, byte_t k2, byte_t k3);
    state_t r;
    byte_t b;
    for (int c = 0; c < 4; c++)
      for (int row = 0; row < 4; row++)
      begin
        b = gmul(k0, getByte(s, 4*c + row)) ^ gmul(k1, getByte(s, 4*c + (row + 1) % 4))
          ^ gmul(k2, getByte(s, 4*c + (row + 2) % 4)) ^ gmul(k3, getByte(s, 4*c + (row + 3) % 4));
        r[127 - 8*(4*c + row) -: 8] = b;
      end
    return r;
  endfunction

  function automatic state_t mixColumns(state_t s);
    return mixState(s, 8'h02, 8'h03, 8'h01, 8'h01);
  endfunction

  function automatic state_t invMixColumns(state_t s);
    return mixState(s, 8'h0e, 8'h0b, 8'h0d, 8'h09);
  endfunction

  function automatic state_t addRoundKey(state_t s, roundKey_t k);
    return s ^ k;
  endfunction

  // Key schedule helpers
  function automatic word_t rotWord(word_t w);
    return {w[23:0], w[31:24]};
  endfunction

  function automatic word_t subWord(word_t w);
    return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
  endfunction

  // Round constant in the top byte, zero for index 0
  function automatic word_t rcon(roundIdx_t i);
    byte_t rc;
    case (i)
      4'd1:    rc = 8'h01;
      4'd2:    rc = 8'h02;
      4'd3:    rc = 8'h04;
      4'd4:    rc = 8'h08;
      4'd5:    rc = 8'h10;
      4'd6:    rc = 8'h20;
      4'd7:    rc = 8'h40;
      4'd8:    rc = 8'h80;
      4'd9:    rc = 8'h1b;
      4'd10:   rc = 8'h36;
      default: rc = 8'h00;
    endcase
    return {rc, 24'h000000};
  endfunction

endpackage

//--- hw/AesUnit.sv
// AES-128 cipher unit
// Key expander, shared round-key store, and encrypt and decrypt cores side by side

`timescale 1ns/10ps

module AesUnit (
  input  logic              clock,
  input  logic              reset,
  input  logic              keyValid,
  output logic              keyReady,
  input  AesPkg::roundKey_t key,
  input  logic              encInValid,
  output logic              encInReady,
  input  AesPkg::state_t    encIn,
  output logic              encOutValid,
  input  logic              encOutReady,
  output AesPkg::state_t    encOut,
  input  logic              decInValid,
  output logic              decInReady,
  input  AesPkg::state_t    decIn,
  output logic              decOutValid,
  input  logic              decOutReady,
  output AesPkg::state_t    decOut
);

  logic              encBusy;
  logic              decBusy;
  logic              wrEn;
  AesPkg::roundIdx_t wrIdx;
  AesPkg::roundKey_t wrKey;

  RoundKeyBus encBus ();
  RoundKeyBus decBus ();

  KeyExpander u_KeyExpander (
    .clock    (clock),
    .reset    (reset),
    .keyValid (keyValid),
    .keyReady (keyReady),
    .key      (key),
    .encBusy  (encBusy),
    .decBusy  (decBusy),
    .wrEn     (wrEn),
    .wrIdx    (wrIdx),
    .wrKey    (wrKey)
  );

  // Key-set status is only needed inside the store
  RoundKeyStore u_RoundKeyStore (
    .clock      (clock),
    .reset      (reset),
    .wrEn       (wrEn),
    .wrIdx      (wrIdx),
    .wrKey      (wrKey),
    .keysLoaded (),
    .encBus     (encBus.store),
    .decBus     (decBus.store)
  );

  EncryptCore u_EncryptCore (
    .clock    (clock),
    .reset    (reset),
    .inValid  (encInValid),
    .inReady  (encInReady),
    .inBlock  (encIn),
    .outValid (encOutValid),
    .outReady (encOutReady),
    .outBlock (encOut),
    .busy     (encBusy),
    .keyBus   (encBus.requester)
  );

  DecryptCore u_DecryptCore (
    .clock    (clock),
    .reset    (reset),
    .inValid  (decInValid),
    .inReady  (decInReady),
    .inBlock  (decIn),
    .outValid (decOutValid),
    .outReady (decOutReady),
    .outBlock (decOut),
    .busy     (decBusy),
    .keyBus   (decBus.requester)
  );

endmodule

//--- hw/DecryptCore.sv
// AES-128 decryption core
// Iterative inverse cipher, fetches round keys from 10 down to 0

`timescale 1ns/10ps

module DecryptCore (
  input  logic           clock,
  input  logic           reset,
  input  logic           inValid,
  output logic           inReady,
  input  AesPkg::state_t inBlock,
  output logic           outValid,
  input  logic           outReady,
  output AesPkg::state_t outBlock,
  output logic           busy,
  RoundKeyBus.requester  keyBus
);

  typedef enum logic [1:0] {Idle, Fetch, Wait, Done} coreState_t;

  coreState_t        state;
  AesPkg::roundIdx_t round;
  AesPkg::state_t    data;
  AesPkg::state_t    nextData;
  AesPkg::state_t    keyed;

  assign inReady    = (state == Idle);
  assign outValid   = (state == Done);
  assign busy       = (state != Idle);
  assign outBlock   = data;
  assign keyBus.req = (state == Fetch);
  assign keyBus.idx = round;

  // Inverse round order: InvShiftRows, InvSubBytes, AddRoundKey, InvMixColumns
  always_comb
  begin
    keyed = AesPkg::addRoundKey(AesPkg::invSubBytes(AesPkg::invShiftRows(data)), keyBus.rkey);
    if (round == AesPkg::NumRounds)
      // Initial whitening with the last round key
      nextData = AesPkg::addRoundKey(data, keyBus.rkey);
    else if (round == '0)
      nextData = keyed;
    else
      nextData = AesPkg::invMixColumns(keyed);
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state <= Idle;
      round <= '0;
    end
    else
    begin
      case (state)
        Idle:
          if (inValid)
          begin
            state <= Fetch;
            round <= AesPkg::NumRounds;
          end
        Fetch:
          if (keyBus.gnt)
            state <= Wait;
        Wait:
          if (keyBus.rkValid)
          begin
            if (round == '0)
              state <= Done;
            else
            begin
              round <= round - 4'd1;
              state <= Fetch;
            end
          end
        default:
          if (outReady)
            state <= Idle;
      endcase
    end
  end

  // Ciphertext in at acceptance, updated once per round
  always_ff @(posedge clock)
  begin
    if (state == Idle && inValid)
      data <= inBlock;
    else if (state == Wait && keyBus.rkValid)
      data <= nextData;
  end

  // Back-pressure keeps the plaintext offered and steady
  assert property (@(posedge clock) disable iff (reset)
    outValid && !outReady |=> outValid && $stable(outBlock));

endmodule

//--- hw/EncryptCore.sv
// AES-128 encryption core
// Iterative forward cipher, one round per fetched round key, keys 0 up to 10

`timescale 1ns/10ps

module EncryptCore (
  input  logic           clock,
  input  logic           reset,
  input  logic           inValid,
  output logic           inReady,
  input  AesPkg::state_t inBlock,
  output logic           outValid,
  input  logic           outReady,
  output AesPkg::state_t outBlock,
  output logic           busy,
  RoundKeyBus.requester  keyBus
);

  typedef enum logic [1:0] {Idle, Fetch, Wait, Done} coreState_t;

  coreState_t        state;
  AesPkg::roundIdx_t round;
  AesPkg::state_t    data;
  AesPkg::state_t    nextData;

  assign inReady    = (state == Idle);
  assign outValid   = (state == Done);
  assign busy       = (state != Idle);
  assign outBlock   = data;
  assign keyBus.req = (state == Fetch);
  assign keyBus.idx = round;

  // Round transform for the key now on the bus
  always_comb
  begin
    if (round == '0)
      nextData = AesPkg::addRoundKey(data, keyBus.rkey);
    else if (round == AesPkg::NumRounds)
      // Final round has no MixColumns
      nextData = AesPkg::addRoundKey(AesPkg::shiftRows(AesPkg::subBytes(data)), keyBus.rkey);
    else
      nextData = AesPkg::addRoundKey(
        AesPkg::mixColumns(AesPkg::shiftRows(AesPkg::subBytes(data))), keyBus.rkey);
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state <= Idle;
      round <= '0;
    end
    else
    begin
      case (state)
        Idle:
          if (inValid)
          begin
            state <= Fetch;
            round <= '0;
          end
        Fetch:
          if (keyBus.gnt)
            state <= Wait;
        Wait:
          if (keyBus.rkValid)
          begin
            if (round == AesPkg::NumRounds)
              state <= Done;
            else
            begin
              round <= round + 4'd1;
              state <= Fetch;
            end
          end
        default:
          // Done holds the result until it is taken
          if (outReady)
            state <= Idle;
      endcase
    end
  end

  // Block register, loaded at acceptance and after every round
  always_ff @(posedge clock)
  begin
    if (state == Idle && inValid)
      data <= inBlock;
    else if (state == Wait && keyBus.rkValid)
      data <= nextData;
  end

  // A stalled result stays offered and unchanged
  assert property (@(posedge clock) disable iff (reset)
    outValid && !outReady |=> outValid && $stable(outBlock));

endmodule

//--- hw/KeyExpander.sv
// AES-128 key expander
// Takes a cipher key and writes round keys 0 to 10 into the store, one per cycle

`timescale 1ns/10ps

module KeyExpander (
  input  logic              clock,
  input  logic              reset,
  input  logic              keyValid,
  output logic              keyReady,
  input  AesPkg::roundKey_t key,
  input  logic              encBusy,
  input  logic              decBusy,
  output logic              wrEn,
  output AesPkg::roundIdx_t wrIdx,
  output AesPkg::roundKey_t wrKey
);

  typedef enum logic {Idle, Expand} expState_t;

  expState_t         state;
  AesPkg::roundIdx_t roundCnt;
  // Last key written, or the cipher key before index 0
  AesPkg::roundKey_t prevKey;
  AesPkg::word_t     schedTerm;
  AesPkg::word_t     w0;
  AesPkg::word_t     w1;
  AesPkg::word_t     w2;
  AesPkg::word_t     w3;

  // New key only while neither core holds a block
  assign keyReady = (state == Idle) && !encBusy && !decBusy;
  assign wrEn     = (state == Expand);
  assign wrIdx    = roundCnt;

  always_comb
  begin
    schedTerm = AesPkg::subWord(AesPkg::rotWord(prevKey[31:0])) ^ AesPkg::rcon(roundCnt);
    w0 = prevKey[127:96] ^ schedTerm;
    w1 = prevKey[95:64] ^ w0;
    w2 = prevKey[63:32] ^ w1;
    w3 = prevKey[31:0] ^ w2;
    // Index 0 is the cipher key as loaded
    wrKey = (roundCnt == '0) ? prevKey : {w0, w1, w2, w3};
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state    <= Idle;
      roundCnt <= '0;
    end
    else if (state == Idle)
    begin
      if (keyValid && keyReady)
      begin
        state    <= Expand;
        roundCnt <= '0;
      end
    end
    else if (roundCnt == AesPkg::NumRounds)
    begin
      state    <= Idle;
      roundCnt <= '0;
    end
    else
      roundCnt <= roundCnt + 4'd1;
  end

  // Chain register for the schedule
  always_ff @(posedge clock)
  begin
    if (state == Idle && keyValid && keyReady)
      prevKey <= key;
    else if (state == Expand)
      prevKey <= wrKey;
  end

  // Writes stay inside the 11-entry store
  assert property (@(posedge clock) disable iff (reset)
    wrEn |-> wrIdx <= AesPkg::NumRounds);

endmodule

//--- hw/RoundKeyBus.sv
// Round-key read channel
// One core's request for a round key and the store's registered reply

`timescale 1ns/10ps

interface RoundKeyBus;

  // Request held until granted
  logic              req;
  AesPkg::roundIdx_t idx;
  logic              gnt;

  // Reply arrives one cycle after the grant
  logic              rkValid;
  AesPkg::roundKey_t rkey;

  modport requester (
    output req,
    output idx,
    input  gnt,
    input  rkValid,
    input  rkey
  );

  modport store (
    input  req,
    input  idx,
    output gnt,
    output rkValid,
    output rkey
  );

endinterface

//--- hw/RoundKeyStore.sv
// Round-key store
// Holds the expanded key set and serves both cores through a round-robin arbiter

`timescale 1ns/10ps

module RoundKeyStore (
  input  logic              clock,
  input  logic              reset,
  input  logic              wrEn,
  input  AesPkg::roundIdx_t wrIdx,
  input  AesPkg::roundKey_t wrKey,
  output logic              keysLoaded,
  RoundKeyBus.store         encBus,
  RoundKeyBus.store         decBus
);

  AesPkg::roundKey_t keyRegs [0:AesPkg::NumRounds];
  // Set when the decrypt core won the last grant
  logic              lastDec;
  logic              canGrant;

  // No reads while a schedule is being written
  assign canGrant = keysLoaded && !wrEn;

  // On conflict the core that lost last time is served
  assign encBus.gnt = canGrant && encBus.req && (!decBus.req || lastDec);
  assign decBus.gnt = canGrant && decBus.req && (!encBus.req || !lastDec);

  always_ff @(posedge clock)
  begin
    if (wrEn)
      keyRegs[wrIdx] <= wrKey;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      keysLoaded     <= 1'b0;
      lastDec        <= 1'b0;
      encBus.rkValid <= 1'b0;
      decBus.rkValid <= 1'b0;
    end
    else
    begin
      // First write clears it, the write of the last index sets it
      if (wrEn)
        keysLoaded <= (wrIdx == AesPkg::NumRounds);
      if (encBus.gnt)
        lastDec <= 1'b0;
      else if (decBus.gnt)
        lastDec <= 1'b1;
      encBus.rkValid <= encBus.gnt;
      decBus.rkValid <= decBus.gnt;
    end
  end

  // Read data registered per bus, held until the next grant
  always_ff @(posedge clock)
  begin
    if (encBus.gnt)
      encBus.rkey <= keyRegs[encBus.idx];
    if (decBus.gnt)
      decBus.rkey <= keyRegs[decBus.idx];
  end

  // At most one core is served per cycle
  assert property (@(posedge clock) disable iff (reset)
    !(encBus.gnt && decBus.gnt));

  // Nothing is handed out from a partial key set
  assert property (@(posedge clock) disable iff (reset)
    (encBus.gnt || decBus.gnt) |-> keysLoaded);

endmodule

//--- tests/AesChecker.sv
// AES unit checker
// Reference AES-128 model with per-core queues of expected results, plus the key-load rule

`timescale 1ns/10ps

module AesChecker (
  input  logic              clock,
  input  logic              reset,
  input  logic              keyValid,
  input  logic              keyReady,
  input  AesPkg::roundKey_t key,
  input  logic              encInValid,
  input  logic              encInReady,
  input  AesPkg::state_t    encIn,
  input  logic              encOutValid,
  input  logic              encOutReady,
  input  AesPkg::state_t    encOut,
  input  logic              decInValid,
  input  logic              decInReady,
  input  AesPkg::state_t    decIn,
  input  logic              decOutValid,
  input  logic              decOutReady,
  input  AesPkg::state_t    decOut,
  output int                encSeen,
  output int                decSeen,
  output int                mismatches
);

  // Model round keys for the key most recently accepted
  AesPkg::roundKey_t rk [0:10];
  // Expected results, oldest first, one block in flight per core
  AesPkg::state_t    encQ [$];
  AesPkg::state_t    decQ [$];

  initial
  begin
    encSeen    = 0;
    decSeen    = 0;
    mismatches = 0;
  end

  // Word-wise key schedule, 44 words
  task automatic expandKey(input AesPkg::roundKey_t k);
    AesPkg::word_t w [0:43];
    AesPkg::word_t t;
    for (int i = 0; i < 4; i++)
      w[i] = k[127 - 32*i -: 32];
    for (int i = 4; i < 44; i++)
    begin
      t = w[i - 1];
      if (i % 4 == 0)
        t = AesPkg::subWord(AesPkg::rotWord(t)) ^ AesPkg::rcon(AesPkg::roundIdx_t'(i / 4));
      w[i] = w[i - 4] ^ t;
    end
    for (int r = 0; r <= 10; r++)
      rk[r] = {w[4*r], w[4*r + 1], w[4*r + 2], w[4*r + 3]};
  endtask

  function automatic AesPkg::state_t cipher(AesPkg::state_t pt);
    AesPkg::state_t s;
    s = pt ^ rk[0];
    for (int r = 1; r < 10; r++)
      s = AesPkg::mixColumns(AesPkg::shiftRows(AesPkg::subBytes(s))) ^ rk[r];
    return AesPkg::shiftRows(AesPkg::subBytes(s)) ^ rk[10];
  endfunction

  function automatic AesPkg::state_t invCipher(AesPkg::state_t ct);
    AesPkg::state_t s;
    s = ct ^ rk[10];
    for (int r = 9; r > 0; r--)
      s = AesPkg::invMixColumns(AesPkg::invSubBytes(AesPkg::invShiftRows(s)) ^ rk[r]);
    return AesPkg::invSubBytes(AesPkg::invShiftRows(s)) ^ rk[0];
  endfunction

  task automatic compareOutput(input string name, input AesPkg::state_t exp,
                               input AesPkg::state_t got);
    if (got !== exp)
    begin
      $display("[ERROR] %0d ns %0s expected %h got %h", $time, name, exp, got);
      mismatches++;
    end
  endtask

  // Falling edge, so the transfer on the next rising edge is already settled
  always @(negedge clock)
  begin
    if (!reset)
    begin
      if (keyReady && (encQ.size() != 0 || decQ.size() != 0))
      begin
        $display("keyReady went high at %0d ns while a core held an undelivered block", $time);
        mismatches++;
      end
      // Key first, a block accepted on the same edge already runs with it
      if (keyValid && keyReady)
        expandKey(key);
      if (encInValid && encInReady)
        encQ.push_back(cipher(encIn));
      if (decInValid && decInReady)
        decQ.push_back(invCipher(decIn));
      if (encOutValid && encOutReady)
      begin
        if (encQ.size() == 0)
        begin
          $display("encOut delivered a block at %0d ns that was never accepted", $time);
          mismatches++;
        end
        else
          compareOutput("encOut", encQ.pop_front(), encOut);
        encSeen++;
      end
      if (decOutValid && decOutReady)
      begin
        if (decQ.size() == 0)
        begin
          $display("decOut delivered a block at %0d ns that was never accepted", $time);
          mismatches++;
        end
        else
          compareOutput("decOut", decQ.pop_front(), decOut);
        decSeen++;
      end
    end
  end

endmodule

//--- tests/AesUnitTb.sv
// AES unit testbench
// LFSR-driven keys and blocks, known-answer and round-trip checks, timeout and summary

`timescale 1ns/10ps

module AesUnitTb;

  localparam int ResetCycles = 16;
  // Known answer 2, encrypt 64, decrypt 64, contention 96, stalls 64, reload 32
  localparam int TotalBlocks = 322;
  localparam int KeyLoads    = 3;
  localparam int TimeoutCycles = TotalBlocks * 60 + KeyLoads * 200 + ResetCycles;

  logic              clock;
  logic              reset;
  logic              keyValid;
  logic              keyReady;
  AesPkg::roundKey_t key;
  logic              encInValid;
  logic              encInReady;
  AesPkg::state_t    encIn;
  logic              encOutValid;
  logic              encOutReady;
  AesPkg::state_t    encOut;
  logic              decInValid;
  logic              decInReady;
  AesPkg::state_t    decIn;
  logic              decOutValid;
  logic              decOutReady;
  AesPkg::state_t    decOut;
  int                encSeen;
  int                decSeen;
  int                mismatches;

  logic [31:0]    lfsr = 32'h5a78a687;
  logic           stallOutputs = 1'b0;
  string          testName = "reset";
  int             encSent = 0;
  int             decSent = 0;
  int             tbErrors = 0;
  int             errBase = 0;
  int             testsRun = 0;
  int             cycleCount = 0;
  AesPkg::state_t encInQ [$];
  AesPkg::state_t encOutQ [$];
  AesPkg::state_t decOutQ [$];
  AesPkg::state_t ptSaved [$];
  AesPkg::state_t ctSaved [$];

  AesUnit u_AesUnit (.*);

  AesChecker u_AesChecker (.*);

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int n, output logic [127:0] v);
    v = '0;
    repeat (n)
    begin
      lfsr = lfsrStep(lfsr);
      v = {v[126:0], lfsr[0]};
    end
  endtask

  // Drive tasks start and end 2 ns after a rising edge
  task automatic idleGap();
    logic [127:0] g;
    drawBits(2, g);
    repeat (g[1:0])
    begin
      @(posedge clock);
      #2;
    end
  endtask

  task automatic loadKey(input AesPkg::roundKey_t k);
    key = k;
    keyValid = 1'b1;
    do
      @(negedge clock);
    while (!keyReady);
    @(posedge clock);
    #2;
    keyValid = 1'b0;
  endtask

  task automatic sendEnc(input AesPkg::state_t blk);
    encIn = blk;
    encInValid = 1'b1;
    do
      @(negedge clock);
    while (!encInReady);
    @(posedge clock);
    #2;
    encInValid = 1'b0;
    encInQ.push_back(blk);
    encSent++;
    idleGap();
  endtask

  task automatic sendDec(input AesPkg::state_t blk);
    decIn = blk;
    decInValid = 1'b1;
    do
      @(negedge clock);
    while (!decInReady);
    @(posedge clock);
    #2;
    decInValid = 1'b0;
    decSent++;
    idleGap();
  endtask

  task automatic drainOutputs();
    while (encSeen < encSent || decSeen < decSent)
    begin
      @(posedge clock);
      #2;
    end
  endtask

  // Random blocks on both cores at once
  task automatic runBatch(input int nEnc, input int nDec);
    fork
      begin
        logic [127:0] v;
        for (int i = 0; i < nEnc; i++)
        begin
          drawBits(128, v);
          sendEnc(v);
        end
      end
      begin
        logic [127:0] v;
        for (int i = 0; i < nDec; i++)
        begin
          drawBits(128, v);
          sendDec(v);
        end
      end
    join
    drainOutputs();
  endtask

  task automatic expectBlock(input string name, input AesPkg::state_t exp,
                             input AesPkg::state_t got);
    if (got !== exp)
    begin
      $display("[ERROR] %0d ns %0s expected %h got %h", $time, name, exp, got);
      tbErrors++;
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    encInQ.delete();
    encOutQ.delete();
    decOutQ.delete();
  endtask

  task automatic reportTest();
    int delta;
    delta = tbErrors + mismatches - errBase;
    $display("Test %0s: %0s, %0d errors", testName, (delta == 0) ? "ok" : "mismatch", delta);
    errBase = tbErrors + mismatches;
    testsRun++;
  endtask

  initial
  begin
    clock = 1'b0;
    forever
      #20 clock = ~clock;
  end

  // Output ready, always on or random per cycle
  initial
  begin
    logic [127:0] r;
    forever
    begin
      @(posedge clock);
      #2;
      if (stallOutputs)
      begin
        drawBits(1, r);
        encOutReady = r[0];
        drawBits(1, r);
        decOutReady = r[0];
      end
      else
      begin
        encOutReady = 1'b1;
        decOutReady = 1'b1;
      end
    end
  end

  // Delivered outputs, in order
  always @(negedge clock)
  begin
    if (!reset && encOutValid && encOutReady)
      encOutQ.push_back(encOut);
    if (!reset && decOutValid && decOutReady)
      decOutQ.push_back(decOut);
  end

  initial
  begin
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, test %0s stalled", cycleCount, testName);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    logic [127:0] k;
    reset = 1'b1;
    keyValid = 1'b0;
    key = '0;
    encInValid = 1'b0;
    encIn = '0;
    encOutReady = 1'b0;
    decInValid = 1'b0;
    decIn = '0;
    decOutReady = 1'b0;
    repeat (ResetCycles) @(posedge clock);
    #2;
    reset = 1'b0;

    // FIPS-197 appendix C.1
    startTest("known answer");
    loadKey(128'h000102030405060708090a0b0c0d0e0f);
    sendEnc(128'h00112233445566778899aabbccddeeff);
    sendDec(128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    drainOutputs();
    expectBlock("encOut", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, encOutQ[0]);
    expectBlock("decOut", 128'h00112233445566778899aabbccddeeff, decOutQ[0]);
    reportTest();

    startTest("random encrypt");
    drawBits(128, k);
    loadKey(k);
    runBatch(64, 0);
    reportTest();

    // Ciphertexts of the last test come back as plaintexts
    ptSaved = encInQ;
    ctSaved = encOutQ;
    startTest("round trip decrypt");
    foreach (ctSaved[i])
      sendDec(ctSaved[i]);
    drainOutputs();
    foreach (ptSaved[i])
      expectBlock("decOut", ptSaved[i], decOutQ[i]);
    reportTest();

    startTest("contention");
    runBatch(48, 48);
    reportTest();

    startTest("output stalls");
    stallOutputs = 1'b1;
    runBatch(32, 32);
    stallOutputs = 1'b0;
    reportTest();

    startTest("key reload");
    drawBits(128, k);
    loadKey(k);
    sendEnc(ptSaved[0]);
    runBatch(15, 16);
    if (encOutQ[0] === ctSaved[0])
    begin
      $display("encOut did not change after the key was reloaded");
      tbErrors++;
    end
    reportTest();

    $display("%0d tests, %0d outputs checked, %0d errors", testsRun, encSeen + decSeen,
             tbErrors + mismatches);
    if (tbErrors + mismatches == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- vlog.f
hw/AesPkg.sv
hw/RoundKeyBus.sv
hw/KeyExpander.sv
hw/RoundKeyStore.sv
hw/EncryptCore.sv
hw/DecryptCore.sv
hw/AesUnit.sv
tests/AesChecker.sv
tests/AesUnitTb.sv
